// File: array_mem_pkg.sv
`default_nettype none

package array_mem_pkg;

  // Target memory, taken from AXI address bits 16:15
  typedef enum logic [1:0] {
    SEL_CONTROLLER = 2'd0,
    SEL_MOD        = 2'd1,
    SEL_DUTY_TABLE = 2'd2
  } bram_select_e;

  typedef struct packed {
    logic        en;
    logic        we;
    logic [1:0]  select;
    logic [13:0] addr;
    logic [15:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [5:0] cnt_sel;
    logic [7:0] offset;
  } ctl_addr_t;

  // Controller accesses use the page view, table accesses the flat index
  typedef union packed {
    ctl_addr_t   ctl;
    logic [13:0] flat;
  } mem_addr_u;

  localparam logic [5:0] CNT_SEL_MAIN = 6'd0;

  // Controller register offsets
  localparam logic [7:0] ADDR_CTL_FLAG       = 8'd0;
  localparam logic [7:0] ADDR_MOD_CONFIG     = 8'd1;
  localparam logic [7:0] ADDR_MOD_WR_SEGMENT = 8'd2;
  localparam logic [7:0] ADDR_MOD_RD_SEGMENT = 8'd3;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef struct packed {
    logic        valid;
    logic        segment;
    logic [13:0] idx;
    logic [7:0]  intensity;
  } seq_out_t;

endpackage

`default_nettype wire

// File: array_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module array_mem_top #(
  parameter int NUM_SEGMENT = 2,
  parameter int MOD_DEPTH   = 1024,
  parameter int CTL_DEPTH   = 256
) (
  input  logic                    bus_clk,
  input  logic                    rst_n,
  input  logic [16:0]             awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [31:0]             wdata,
  input  logic [3:0]              wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logic [16:0]             araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logic [31:0]             rdata,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  logic                    rready,
  output array_mem_pkg::seq_out_t seq_out
);

  array_mem_pkg::mem_req_t req;
  logic [15:0]             mem_rdata;
  logic [7:0]              ctl_raddr;
  logic [15:0]             ctl_rdata;
  logic [13:0]             mod_idx;
  logic                    mod_seg;
  logic [7:0]              mod_value;
  logic [7:0]              duty_idx;
  logic [7:0]              duty_value;

  axil_mem_bridge bridge_i (
    .bus_clk  (bus_clk),
    .rst_n    (rst_n),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .wready   (wready),
    .bresp    (bresp),
    .bvalid   (bvalid),
    .bready   (bready),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (rdata),
    .rresp    (rresp),
    .rvalid   (rvalid),
    .rready   (rready),
    .req      (req),
    .mem_rdata(mem_rdata)
  );

  memory_map #(
    .NUM_SEGMENT(NUM_SEGMENT),
    .MOD_DEPTH  (MOD_DEPTH),
    .CTL_DEPTH  (CTL_DEPTH)
  ) memory_map_i (
    .bus_clk   (bus_clk),
    .rst_n     (rst_n),
    .req       (req),
    .rdata     (mem_rdata),
    .ctl_raddr (ctl_raddr),
    .ctl_rdata (ctl_rdata),
    .mod_idx   (mod_idx),
    .mod_seg   (mod_seg),
    .mod_value (mod_value),
    .duty_idx  (duty_idx),
    .duty_value(duty_value)
  );

  modulation_sequencer #(
    .MOD_DEPTH(MOD_DEPTH)
  ) sequencer_i (
    .bus_clk   (bus_clk),
    .rst_n     (rst_n),
    .ctl_raddr (ctl_raddr),
    .ctl_rdata (ctl_rdata),
    .mod_idx   (mod_idx),
    .mod_seg   (mod_seg),
    .mod_value (mod_value),
    .duty_idx  (duty_idx),
    .duty_value(duty_value),
    .seq_out   (seq_out)
  );

endmodule

`default_nettype wire

// File: axil_mem_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module axil_mem_bridge (
  input  logic                    bus_clk,
  input  logic                    rst_n,
  input  logic [16:0]             awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [31:0]             wdata,
  input  logic [3:0]              wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logic [16:0]             araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logic [31:0]             rdata,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  logic                    rready,
  output array_mem_pkg::mem_req_t req,
  input  logic [15:0]             mem_rdata
);

  logic [1:0]                wr_sel;
  logic [1:0]                rd_sel;
  array_mem_pkg::mem_addr_u  wr_word;
  array_mem_pkg::mem_addr_u  rd_word;
  logic                      wr_err;
  logic                      rd_err;
  logic                      wr_accept;
  logic                      rd_accept;
  logic                      rd_pend;
  logic                      rd_pend_err;

  // Controller page is read/write, both tables are write only
  function automatic logic decode_err(input logic [1:0] sel,
                                      input array_mem_pkg::mem_addr_u word,
                                      input logic is_read);
    logic ctl_ok;
    ctl_ok = (sel == array_mem_pkg::SEL_CONTROLLER) &&
             (word.ctl.cnt_sel == array_mem_pkg::CNT_SEL_MAIN);
    if (is_read) begin
      return !ctl_ok;
    end
    return !(ctl_ok || (sel == array_mem_pkg::SEL_MOD) ||
             (sel == array_mem_pkg::SEL_DUTY_TABLE));
  endfunction

  // Byte address to 16-bit word address
  assign wr_sel  = awaddr[16:15];
  assign wr_word = awaddr[14:1];
  assign rd_sel  = araddr[16:15];
  assign rd_word = araddr[14:1];

  assign wr_err = decode_err(wr_sel, wr_word, 1'b0);
  assign rd_err = decode_err(rd_sel, rd_word, 1'b1);

  // Write wins over a read in the same cycle
  assign wr_accept = awvalid && wvalid && !bvalid;
  assign rd_accept = arvalid && !rd_pend && !rvalid && !wr_accept;

  assign awready = wr_accept;
  assign wready  = wr_accept;
  assign arready = rd_accept;

  // Request is issued in the accepting cycle, suppressed on decode errors
  always_comb begin
    req = '0;
    if (wr_accept) begin
      req.en     = !wr_err && (wstrb[1:0] != 2'b00);
      req.we     = 1'b1;
      req.select = wr_sel;
      req.addr   = wr_word.flat;
      req.wdata  = wdata[15:0];
    end else if (rd_accept) begin
      req.en     = !rd_err;
      req.select = rd_sel;
      req.addr   = rd_word.flat;
    end
  end

  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      bvalid  <= 1'b0;
      rd_pend <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      if (wr_accept) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      // First stage waits for the RAM, second captures its output
      rd_pend <= rd_accept;
      if (rd_pend) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge bus_clk) begin
    if (wr_accept) begin
      bresp <= wr_err ? array_mem_pkg::RESP_SLVERR : array_mem_pkg::RESP_OKAY;
    end
    if (rd_accept) begin
      rd_pend_err <= rd_err;
    end
    if (rd_pend) begin
      rresp <= rd_pend_err ? array_mem_pkg::RESP_SLVERR : array_mem_pkg::RESP_OKAY;
      rdata <= rd_pend_err ? 32'h0 : {16'h0000, mem_rdata};
    end
  end

endmodule

`default_nettype wire

// File: dp_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dp_ram #(
  parameter int DEPTH = 256,
  parameter int WIDTH = 16
) (
  input  logic                     bus_clk,
  input  logic                     a_en,
  input  logic                     a_we,
  input  logic [$clog2(DEPTH)-1:0] a_addr,
  input  logic [WIDTH-1:0]         a_wdata,
  output logic [WIDTH-1:0]         a_rdata,
  input  logic [$clog2(DEPTH)-1:0] b_addr,
  output logic [WIDTH-1:0]         b_rdata
);

  // Block RAM powers up cleared
  logic [WIDTH-1:0] mem [DEPTH] = '{default: '0};

  // Port a, bus side, read-first
  always_ff @(posedge bus_clk) begin
    if (a_en) begin
      if (a_we) begin
        mem[a_addr] <= a_wdata;
      end
      a_rdata <= mem[a_addr];
    end
  end

  // Port b, consumer side, read only
  always_ff @(posedge bus_clk) begin
    b_rdata <= mem[b_addr];
  end

endmodule

`default_nettype wire

// File: files.f
array_mem_pkg.sv
dp_ram.sv
axil_mem_bridge.sv
memory_map.sv
modulation_sequencer.sv
array_mem_top.sv
tb_clock_gen.sv
tb_array_mem_assertions.sv
tb_array_mem.sv

// File: memory_map.sv
`timescale 1ns/1ps
`default_nettype none

module memory_map #(
  parameter int NUM_SEGMENT = 2,
  parameter int MOD_DEPTH   = 1024,
  parameter int CTL_DEPTH   = 256
) (
  input  logic                    bus_clk,
  input  logic                    rst_n,
  input  array_mem_pkg::mem_req_t req,
  output logic [15:0]             rdata,
  input  logic [7:0]              ctl_raddr,
  output logic [15:0]             ctl_rdata,
  input  logic [13:0]             mod_idx,
  input  logic                    mod_seg,
  output logic [7:0]              mod_value,
  input  logic [7:0]              duty_idx,
  output logic [7:0]              duty_value
);

  localparam int CTL_AW = $clog2(CTL_DEPTH);
  localparam int MOD_AW = $clog2(MOD_DEPTH);

  array_mem_pkg::mem_addr_u addr;
  logic                     ctl_en;
  logic                     duty_en;
  logic [NUM_SEGMENT-1:0]   mod_en;
  logic [7:0]               mod_rd [NUM_SEGMENT];
  logic                     mod_wr_seg;
  logic                     mod_seg_q;

  assign addr = req.addr;

  assign ctl_en = req.en && (req.select == array_mem_pkg::SEL_CONTROLLER) &&
                  (addr.ctl.cnt_sel == array_mem_pkg::CNT_SEL_MAIN);
  assign duty_en = req.en && (req.select == array_mem_pkg::SEL_DUTY_TABLE);

  // Controller registers, only RAM readable over the bus
  dp_ram #(
    .DEPTH(CTL_DEPTH),
    .WIDTH(16)
  ) ctl_ram_i (
    .bus_clk(bus_clk),
    .a_en   (ctl_en),
    .a_we   (req.we),
    .a_addr (addr.ctl.offset[CTL_AW-1:0]),
    .a_wdata(req.wdata),
    .a_rdata(rdata),
    .b_addr (ctl_raddr[CTL_AW-1:0]),
    .b_rdata(ctl_rdata)
  );

  // One RAM per segment, writes go to the selected one only
  for (genvar i = 0; i < NUM_SEGMENT; i++) begin : gen_mod_ram
    assign mod_en[i] = req.en && (req.select == array_mem_pkg::SEL_MOD) &&
                       (mod_wr_seg == i);

    dp_ram #(
      .DEPTH(MOD_DEPTH),
      .WIDTH(8)
    ) mod_ram_i (
      .bus_clk(bus_clk),
      .a_en   (mod_en[i]),
      .a_we   (req.we),
      .a_addr (addr.flat[MOD_AW-1:0]),
      .a_wdata(req.wdata[7:0]),
      .a_rdata(),
      .b_addr (mod_idx[MOD_AW-1:0]),
      .b_rdata(mod_rd[i])
    );
  end

  // Segment follows its index through the RAM latency
  always_ff @(posedge bus_clk) begin
    mod_seg_q <= mod_seg;
  end

  assign mod_value = mod_rd[mod_seg_q];

  // Modulation value to drive intensity
  dp_ram #(
    .DEPTH(256),
    .WIDTH(8)
  ) duty_ram_i (
    .bus_clk(bus_clk),
    .a_en   (duty_en),
    .a_we   (req.we),
    .a_addr (addr.flat[7:0]),
    .a_wdata(req.wdata[7:0]),
    .a_rdata(),
    .b_addr (duty_idx),
    .b_rdata(duty_value)
  );

  // Write segment takes effect on the accepting edge
  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      mod_wr_seg <= 1'b0;
    end else if (ctl_en && req.we &&
                 (addr.ctl.offset == array_mem_pkg::ADDR_MOD_WR_SEGMENT)) begin
      mod_wr_seg <= req.wdata[0];
    end
  end

endmodule

`default_nettype wire

// File: modulation_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module modulation_sequencer #(
  parameter int MOD_DEPTH = 1024
) (
  input  logic                    bus_clk,
  input  logic                    rst_n,
  output logic [7:0]              ctl_raddr,
  input  logic [15:0]             ctl_rdata,
  output logic [13:0]             mod_idx,
  output logic                    mod_seg,
  input  logic [7:0]              mod_value,
  output logic [7:0]              duty_idx,
  input  logic [7:0]              duty_value,
  output array_mem_pkg::seq_out_t seq_out
);

  localparam logic [13:0] IDX_MAX = 14'(MOD_DEPTH - 1);

  logic [1:0]  slot;
  logic [1:0]  slot_q;
  logic        run;
  logic [13:0] cycle_last;
  logic        pending_seg;
  logic        active;
  logic [13:0] idx;
  logic        seg;
  logic        wrap;
  logic        s1_valid;
  logic [13:0] s1_idx;
  logic        s1_seg;
  logic        s2_valid;
  logic [13:0] s2_idx;
  logic        s2_seg;

  // Three-slot rotation over the controller words
  always_comb begin
    case (slot)
      2'd0:    ctl_raddr = array_mem_pkg::ADDR_CTL_FLAG;
      2'd1:    ctl_raddr = array_mem_pkg::ADDR_MOD_CONFIG;
      default: ctl_raddr = array_mem_pkg::ADDR_MOD_RD_SEGMENT;
    endcase
  end

  // Config may shrink under a running index
  assign wrap = (idx >= cycle_last) || (idx == IDX_MAX);

  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      slot        <= 2'd0;
      slot_q      <= 2'd0;
      run         <= 1'b0;
      cycle_last  <= '0;
      pending_seg <= 1'b0;
    end else begin
      slot   <= (slot == 2'd2) ? 2'd0 : slot + 2'd1;
      slot_q <= slot;
      case (slot_q)
        2'd0:    run <= ctl_rdata[0];
        2'd1:    cycle_last <= ctl_rdata[13:0];
        default: pending_seg <= ctl_rdata[0];
      endcase
    end
  end

  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      active   <= 1'b0;
      idx      <= '0;
      seg      <= 1'b0;
      s1_valid <= 1'b0;
      s1_idx   <= '0;
      s1_seg   <= 1'b0;
      s2_valid <= 1'b0;
      s2_idx   <= '0;
      s2_seg   <= 1'b0;
    end else begin
      if (!run) begin
        active <= 1'b0;
        idx    <= '0;
      end else if (!active) begin
        active <= 1'b1;
        idx    <= '0;
        seg    <= pending_seg;
      end else if (wrap) begin
        // Played segment only changes here
        idx <= '0;
        seg <= pending_seg;
      end else begin
        idx <= idx + 14'd1;
      end
      // Stage 1 lines up with mod_value, stage 2 with duty_value
      s1_valid <= active;
      s1_idx   <= idx;
      s1_seg   <= seg;
      s2_valid <= s1_valid;
      s2_idx   <= s1_idx;
      s2_seg   <= s1_seg;
    end
  end

  assign mod_idx  = idx;
  assign mod_seg  = seg;
  assign duty_idx = mod_value;

  always_comb begin
    seq_out.valid     = s2_valid;
    seq_out.segment   = s2_seg;
    seq_out.idx       = s2_idx;
    seq_out.intensity = duty_value;
  end

endmodule

`default_nettype wire

// File: tb_array_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_array_mem;

  localparam logic [1:0] OKAY   = 2'b00;
  localparam logic [1:0] SLVERR = 2'b10;
  // Tests need about 8000 cycles, leave more than twice that
  localparam int CYCLE_LIMIT = 20000;

  logic                    bus_clk;
  logic                    rst_n;
  logic [16:0]             awaddr;
  logic                    awvalid;
  logic                    awready;
  logic [31:0]             wdata;
  logic [3:0]              wstrb;
  logic                    wvalid;
  logic                    wready;
  logic [1:0]              bresp;
  logic                    bvalid;
  logic                    bready;
  logic [16:0]             araddr;
  logic                    arvalid;
  logic                    arready;
  logic [31:0]             rdata;
  logic [1:0]              rresp;
  logic                    rvalid;
  logic                    rready;
  array_mem_pkg::seq_out_t seq_out;

  // Reference model of the memories
  logic [15:0] ctl_m [256];
  logic [7:0]  mod_m [2][1024];
  logic [7:0]  duty_m [256];
  logic        wr_seg_m;

  logic [31:0] rng_state = 32'h9373a8a3;
  int          errors = 0;
  int          cycles = 0;
  logic        want_seg = 1'b0;
  int          exp_last = 31;
  int          wrap_count = 0;
  logic        mon_prev_valid = 1'b0;
  logic [13:0] mon_prev_idx;
  logic        mon_prev_seg;
  logic [13:0] exp_idx;
  logic        exp_seg;

  tb_clock_gen clock_gen_i (
    .bus_clk(bus_clk),
    .rst_n  (rst_n)
  );

  array_mem_top dut_i (
    .bus_clk(bus_clk), .rst_n(rst_n),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .seq_out(seq_out)
  );

  bind axil_mem_bridge tb_array_mem_assertions assert_i (
    .bus_clk(bus_clk), .rst_n(rst_n), .awready(awready), .wready(wready),
    .bvalid(bvalid), .bready(bready), .arvalid(arvalid), .arready(arready),
    .rvalid(rvalid), .rready(rready), .rdata(rdata)
  );

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Byte address = {select, word address, 0}
  function automatic logic [16:0] ctl_addr(input logic [5:0] cnt_sel, input logic [7:0] offset);
    return {2'd0, cnt_sel, offset, 1'b0};
  endfunction

  function automatic logic [16:0] table_addr(input logic [1:0] sel, input logic [13:0] idx);
    return {sel, idx, 1'b0};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic axil_write(input logic [16:0] addr, input logic [15:0] data,
                            input logic [1:0] exp_resp);
    @(negedge bus_clk);
    awaddr  = addr;
    wdata   = {16'h0000, data};
    wstrb   = 4'hf;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b0;
    @(negedge bus_clk);
    while (!bvalid) @(negedge bus_clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    check_value("bresp", bresp, exp_resp);
    bready = 1'b1;
    @(negedge bus_clk);
    check_value("bvalid", bvalid, 1'b0);
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [16:0] addr, input logic [1:0] exp_resp,
                           input logic [15:0] exp_data, input int hold);
    @(negedge bus_clk);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b0;
    @(negedge bus_clk);
    while (!rvalid) @(negedge bus_clk);
    arvalid = 1'b0;
    check_value("rresp", rresp, exp_resp);
    if (exp_resp == OKAY) check_value("rdata", rdata, {16'h0000, exp_data});
    // Host stalls, data must hold
    repeat (hold) begin
      @(negedge bus_clk);
      check_value("rvalid", rvalid, 1'b1);
      if (exp_resp == OKAY) check_value("rdata", rdata, {16'h0000, exp_data});
    end
    rready = 1'b1;
    @(negedge bus_clk);
    check_value("rvalid", rvalid, 1'b0);
    rready = 1'b0;
  endtask

  task automatic ctl_write(input logic [7:0] offset, input logic [15:0] data);
    axil_write(ctl_addr(array_mem_pkg::CNT_SEL_MAIN, offset), data, OKAY);
    ctl_m[offset] = data;
    if (offset == array_mem_pkg::ADDR_MOD_WR_SEGMENT) wr_seg_m = data[0];
  endtask

  task automatic wait_wraps(input int n);
    int base;
    @(posedge bus_clk);
    base = wrap_count;
    while (wrap_count < base + n) @(posedge bus_clk);
  endtask

  // Every valid output is checked against the model
  always @(negedge bus_clk) begin
    if (rst_n && seq_out.valid) begin
      if (mon_prev_valid) begin
        exp_idx = (mon_prev_idx >= 14'(exp_last)) ? 14'd0 : mon_prev_idx + 14'd1;
      end else begin
        exp_idx = 14'd0;
      end
      // Played segment is only taken up at a start or a wrap
      exp_seg = (exp_idx == 14'd0) ? want_seg : mon_prev_seg;
      check_value("seq_out.idx", seq_out.idx, exp_idx);
      check_value("seq_out.segment", seq_out.segment, exp_seg);
      check_value("seq_out.intensity", seq_out.intensity,
                  duty_m[mod_m[exp_seg][exp_idx[9:0]]]);
      if (exp_idx == 14'd0) wrap_count++;
      mon_prev_idx = exp_idx;
      mon_prev_seg = exp_seg;
    end
    mon_prev_valid = rst_n && seq_out.valid;
  end

  always @(posedge bus_clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic verify_reset_state();
    check_value("bvalid", bvalid, 1'b0);
    check_value("rvalid", rvalid, 1'b0);
    check_value("awready", awready, 1'b0);
    check_value("wready", wready, 1'b0);
    check_value("arready", arready, 1'b0);
    check_value("seq_out.valid", seq_out.valid, 1'b0);
    check_value("seq_out.idx", seq_out.idx, 14'd0);
  endtask

  task automatic ctl_round_trip();
    logic [31:0] r;
    for (int i = 4; i <= 40; i++) begin
      r = next_random();
      ctl_write(8'(i), r[15:0]);
    end
    for (int i = 4; i <= 40; i++) begin
      axil_read(ctl_addr(6'd0, 8'(i)), OKAY, ctl_m[i], (i % 8 == 0) ? 5 : 0);
    end
  endtask

  task automatic decode_error_cases();
    axil_read(table_addr(array_mem_pkg::SEL_MOD, 14'd5), SLVERR, 16'h0, 0);
    axil_read(table_addr(array_mem_pkg::SEL_DUTY_TABLE, 14'd3), SLVERR, 16'h0, 0);
    axil_read(ctl_addr(6'd1, 8'd6), SLVERR, 16'h0, 0);
    axil_write(ctl_addr(6'd1, 8'd6), 16'hdead, SLVERR);
    axil_write(table_addr(2'd3, 14'd6), 16'hbeef, SLVERR);
    // Offset 6 keeps its earlier value
    axil_read(ctl_addr(6'd0, 8'd6), OKAY, ctl_m[6], 0);
  endtask

  task automatic segmented_mod_playback();
    logic [31:0] r;
    for (int s = 0; s < 2; s++) begin
      ctl_write(array_mem_pkg::ADDR_MOD_WR_SEGMENT, 16'(s));
      for (int i = 0; i < 32; i++) begin
        r = next_random();
        axil_write(table_addr(array_mem_pkg::SEL_MOD, 14'(i)), {8'h00, r[7:0]}, OKAY);
        mod_m[wr_seg_m][i] = r[7:0];
      end
    end
    for (int i = 0; i < 256; i++) begin
      r = next_random();
      axil_write(table_addr(array_mem_pkg::SEL_DUTY_TABLE, 14'(i)), {8'h00, r[7:0]}, OKAY);
      duty_m[i] = r[7:0];
    end
    want_seg = 1'b0;
    exp_last = 31;
    ctl_write(array_mem_pkg::ADDR_MOD_CONFIG, 16'd31);
    ctl_write(array_mem_pkg::ADDR_MOD_RD_SEGMENT, 16'd0);
    ctl_write(array_mem_pkg::ADDR_CTL_FLAG, 16'd1);
    wait_wraps(3);
  endtask

  task automatic segment_switch_at_wrap();
    // Switch early in the cycle so it lands at the next wrap
    @(negedge bus_clk);
    while (!(seq_out.valid && seq_out.idx == 14'd8)) @(negedge bus_clk);
    ctl_write(array_mem_pkg::ADDR_MOD_RD_SEGMENT, 16'd1);
    @(posedge bus_clk);
    want_seg = 1'b1;
    wait_wraps(2);
  endtask

  task automatic stop_and_length_change();
    int n;
    ctl_write(array_mem_pkg::ADDR_CTL_FLAG, 16'd0);
    n = 0;
    while (seq_out.valid && n <= 10) begin
      @(negedge bus_clk);
      n++;
    end
    assert (n <= 10) else begin
      $display("seq_out.valid still high 10 cycles after run was cleared");
      errors++;
    end
    repeat (20) begin
      @(negedge bus_clk);
      assert (!seq_out.valid) else begin
        $display("seq_out.valid came back while run was cleared at t=%0t", $time);
        errors++;
      end
    end
    exp_last = 7;
    ctl_write(array_mem_pkg::ADDR_MOD_CONFIG, 16'd7);
    ctl_write(array_mem_pkg::ADDR_CTL_FLAG, 16'd1);
    wait_wraps(3);
  endtask

  initial begin
    awaddr   = '0;
    awvalid  = 1'b0;
    wdata    = '0;
    wstrb    = '0;
    wvalid   = 1'b0;
    bready   = 1'b0;
    araddr   = '0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    wr_seg_m = 1'b0;
    for (int i = 0; i < 256; i++) begin
      ctl_m[i]  = '0;
      duty_m[i] = '0;
    end
    for (int i = 0; i < 1024; i++) begin
      mod_m[0][i] = '0;
      mod_m[1][i] = '0;
    end
    @(posedge rst_n);
    @(negedge bus_clk);
    verify_reset_state();
    ctl_round_trip();
    decode_error_cases();
    segmented_mod_playback();
    segment_switch_at_wrap();
    stop_and_length_change();
    repeat (5) @(negedge bus_clk);
    $display("Summary: %0d check errors, %0d assertion failures",
             errors, dut_i.bridge_i.assert_i.fail_count);
    if (errors == 0 && dut_i.bridge_i.assert_i.fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_array_mem_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module tb_array_mem_assertions (
  input logic        bus_clk,
  input logic        rst_n,
  input logic        awready,
  input logic        wready,
  input logic        bvalid,
  input logic        bready,
  input logic        arvalid,
  input logic        arready,
  input logic        rvalid,
  input logic        rready,
  input logic [31:0] rdata
);

  int unsigned fail_count = 0;

  bvalid_hold: assert property (@(posedge bus_clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)
  else begin
    fail_count++;
    $error("bvalid dropped before bready");
  end

  // Data must not move while the host stalls
  rvalid_hold: assert property (@(posedge bus_clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata))
  else begin
    fail_count++;
    $error("rvalid or rdata changed before rready");
  end

  // Accepted write is answered on the next edge
  ready_pair: assert property (@(posedge bus_clk) disable iff (!rst_n)
    awready |-> wready ##1 bvalid)
  else begin
    fail_count++;
    $error("awready high without wready or without bvalid on the next edge");
  end

  // RAM edge plus capture edge
  rvalid_source: assert property (@(posedge bus_clk) disable iff (!rst_n)
    $rose(rvalid) |-> $past(arvalid && arready, 2))
  else begin
    fail_count++;
    $error("rvalid rose without an accepted read two cycles earlier");
  end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 5,
  parameter int RESET_CYCLES = 16
) (
  output logic bus_clk,
  output logic rst_n
);

  initial begin
    bus_clk = 1'b0;
    forever #HALF_PERIOD bus_clk = ~bus_clk;
  end

  // Release on a falling edge, clear of the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge bus_clk);
    @(negedge bus_clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire
